// File: include/fifo_defs.svh
/*
 * Size constants for the packet FIFO. Include this wherever the depth or
 * the payload width is needed; the package includes it for its types.
 */

`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// Number of entries the FIFO holds.
`define FIFO_DEPTH 16

// Address width, enough bits to index every entry.
`define FIFO_ADDR_W 4

// Width of the user payload.
// The stored word adds one parity bit on top of this.
`define FIFO_DATA_W 16

`endif

// File: rtl/fifo_pkg.sv
/*
 * Shared types for the packet FIFO: memory address, occupancy count and
 * the stored entry. Modules refer to these by scoped name.
 */

`include "fifo_defs.svh"

package fifo_pkg;

  // Index into the entry storage.
  typedef logic [`FIFO_ADDR_W-1:0] addr_t;

  // One bit wider than the address so that a full FIFO can be counted.
  typedef logic [`FIFO_ADDR_W:0] count_t;

  // Word held in each memory bank.
  // Parity is even parity over the payload, formed on enqueue.
  typedef struct packed {
    logic                    parity;
    logic [`FIFO_DATA_W-1:0] payload;
  } entry_t;

endpackage

// File: rtl/mem_1rw_sync.sv
/*
 * Single-port synchronous RAM bank. One access per cycle, either a write
 * or a read whose word appears on data_o after the clock edge.
 */

`timescale 1ns/1ps

module mem_1rw_sync
  #(parameter type data_t = logic [7:0]
   ,parameter int els_p = 16
   )
  (input                   clk_i
  ,input                   v_i
  ,input                   w_i
  ,input  fifo_pkg::addr_t addr_i
  ,input  data_t           data_i
  ,output data_t           data_o
  );

  data_t mem_r [els_p];
  data_t data_r;

  // A read holds its word on the output until the next read.
  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      if (w_i)
        mem_r[addr_i] <= data_i;
      else
        data_r <= mem_r[addr_i];
    end
  end

  assign data_o = data_r;

endmodule

// File: rtl/mem_1r1w_from_1rw.sv
/*
 * One-read, one-write memory built from two single-port banks. A bank-select
 * table tracks where each address was last written so reads find their data.
 */

`timescale 1ns/1ps

`include "fifo_defs.svh"

module mem_1r1w_from_1rw
  (input                    clk_i
  ,input                    reset_i
  ,input                    w_v_i
  ,input  fifo_pkg::addr_t  w_addr_i
  ,input  fifo_pkg::entry_t w_data_i
  ,input                    r_v_i
  ,input  fifo_pkg::addr_t  r_addr_i
  ,output fifo_pkg::entry_t r_data_o
  );

  // One bit per address, naming the bank that holds its latest write.
  logic [`FIFO_DEPTH-1:0] bank_sel_r;
  logic                   rd_bank_r;

  logic                   r_bank;
  logic                   w_bank;

  logic [1:0]             bank_v;
  logic [1:0]             bank_w;
  fifo_pkg::addr_t        bank_addr [2];
  fifo_pkg::entry_t       bank_data [2];

  assign r_bank = bank_sel_r[r_addr_i];

  // When a read is active the write takes the other bank. Otherwise it
  // simply alternates with whatever that address held before.
  assign w_bank = r_v_i ? ~r_bank : ~bank_sel_r[w_addr_i];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      bank_sel_r <= '0;
    else if (w_v_i)
      bank_sel_r[w_addr_i] <= w_bank;
  end

  // Bank data is registered, so the output mux must use last cycle's choice.
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rd_bank_r <= 1'b0;
    else if (r_v_i)
      rd_bank_r <= r_bank;
  end

  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    assign bank_w[b]    = w_v_i & (w_bank == 1'(b));
    assign bank_v[b]    = bank_w[b] | (r_v_i & (r_bank == 1'(b)));
    assign bank_addr[b] = bank_w[b] ? w_addr_i : r_addr_i;

    mem_1rw_sync
      #(.data_t(fifo_pkg::entry_t)
       ,.els_p(`FIFO_DEPTH)
       )
      bank
      (.clk_i (clk_i)
      ,.v_i   (bank_v[b])
      ,.w_i   (bank_w[b])
      ,.addr_i(bank_addr[b])
      ,.data_i(w_data_i)
      ,.data_o(bank_data[b])
      );
  end

  assign r_data_o = rd_bank_r ? bank_data[1] : bank_data[0];

endmodule

// File: rtl/fifo_ctrl.sv
/*
 * FIFO controller. Turns enqueue and dequeue strobes into memory requests
 * and keeps the pointers and occupancy; strobes that cannot be served are dropped.
 */

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_ctrl
  (input                   clk_i
  ,input                   reset_i
  ,input                   enq_i
  ,input                   deq_i
  ,output logic            w_v_o
  ,output fifo_pkg::addr_t w_addr_o
  ,output logic            r_v_o
  ,output fifo_pkg::addr_t r_addr_o
  ,output fifo_pkg::count_t count_o
  ,output logic            full_o
  ,output logic            empty_o
  );

  fifo_pkg::addr_t  wptr_r;
  fifo_pkg::addr_t  rptr_r;
  fifo_pkg::count_t count_r;

  logic enq_ok;
  logic deq_ok;

  function automatic fifo_pkg::addr_t next_ptr(input fifo_pkg::addr_t ptr);
    if (ptr == fifo_pkg::addr_t'(`FIFO_DEPTH - 1))
      next_ptr = '0;
    else
      next_ptr = ptr + 1'b1;
  endfunction

  assign full_o  = (count_r == fifo_pkg::count_t'(`FIFO_DEPTH));
  assign empty_o = (count_r == '0);
  assign count_o = count_r;

  assign enq_ok = enq_i & ~full_o;
  assign deq_ok = deq_i & ~empty_o;

  // The pointers differ whenever both requests are issued.
  assign w_v_o    = enq_ok;
  assign w_addr_o = wptr_r;
  assign r_v_o    = deq_ok;
  assign r_addr_o = rptr_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wptr_r  <= '0;
      rptr_r  <= '0;
      count_r <= '0;
    end
    else
    begin
      if (enq_ok)
        wptr_r <= next_ptr(wptr_r);
      if (deq_ok)
        rptr_r <= next_ptr(rptr_r);
      case ({enq_ok, deq_ok})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

// File: rtl/fifo_1r1w_top.sv
/*
 * Packet FIFO top level. Enqueue and dequeue are single-cycle strobes; a
 * dequeued word appears with deq_v_o one cycle after the accepted deq_i.
 */

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_1r1w_top
  (input                           clk_i
  ,input                           reset_i
  ,input                           enq_i
  ,input        [`FIFO_DATA_W-1:0] enq_data_i
  ,input                           deq_i
  ,output logic                    deq_v_o
  ,output logic [`FIFO_DATA_W-1:0] deq_data_o
  ,output logic                    parity_err_o
  ,output fifo_pkg::count_t        count_o
  ,output logic                    full_o
  ,output logic                    empty_o
  );

  logic             w_v;
  fifo_pkg::addr_t  w_addr;
  fifo_pkg::entry_t w_data;
  logic             r_v;
  fifo_pkg::addr_t  r_addr;
  fifo_pkg::entry_t r_data;

  fifo_ctrl ctrl
    (.clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.enq_i   (enq_i)
    ,.deq_i   (deq_i)
    ,.w_v_o   (w_v)
    ,.w_addr_o(w_addr)
    ,.r_v_o   (r_v)
    ,.r_addr_o(r_addr)
    ,.count_o (count_o)
    ,.full_o  (full_o)
    ,.empty_o (empty_o)
    );

  assign w_data.payload = enq_data_i;
  assign w_data.parity  = ^enq_data_i;

  mem_1r1w_from_1rw mem
    (.clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.w_v_i   (w_v)
    ,.w_addr_i(w_addr)
    ,.w_data_i(w_data)
    ,.r_v_i   (r_v)
    ,.r_addr_i(r_addr)
    ,.r_data_o(r_data)
    );

  // Memory read latency is one cycle, so the read request lines up here.
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      deq_v_o <= 1'b0;
    else
      deq_v_o <= r_v;
  end

  assign deq_data_o   = r_data.payload;
  assign parity_err_o = deq_v_o & (r_data.parity != ^r_data.payload);

endmodule

// File: testbench/fifo_checker.sv
/*
 * Concurrent assertions on the controller to memory requests and the
 * FIFO status outputs. Bound into the FIFO top level.
 */

`timescale 1ns/1ps

module fifo_checker
  (input                  clk_i
  ,input                  reset_i
  ,input                  deq_i
  ,input                  w_v_i
  ,input fifo_pkg::addr_t w_addr_i
  ,input                  r_v_i
  ,input fifo_pkg::addr_t r_addr_i
  ,input                  full_i
  ,input                  empty_i
  ,input                  deq_v_i
  );

  // The memory has no same-address bypass.
  assert property (@(posedge clk_i) disable iff (reset_i)
    (w_v_i && r_v_i) |-> (w_addr_i != r_addr_i))
    else $error("write and read requests target the same address");

  // The count moves by at most one per cycle, so full and empty never meet.
  assert property (@(posedge clk_i) disable iff (reset_i) full_i |=> !empty_i)
    else $error("empty right after full");

  assert property (@(posedge clk_i) disable iff (reset_i) empty_i |=> !full_i)
    else $error("full right after empty");

  // A dequeue strobe is accepted while the FIFO holds data.
  assert property (@(posedge clk_i) disable iff (reset_i)
    (deq_i && !empty_i) |=> deq_v_i)
    else $error("accepted dequeue not followed by deq_v_o");

  assert property (@(posedge clk_i) disable iff (reset_i)
    !(deq_i && !empty_i) |=> !deq_v_i)
    else $error("deq_v_o high without an accepted dequeue");

endmodule

bind fifo_1r1w_top fifo_checker checks
  (.clk_i(clk_i), .reset_i(reset_i), .deq_i(deq_i)
  ,.w_v_i(w_v), .w_addr_i(w_addr), .r_v_i(r_v), .r_addr_i(r_addr)
  ,.full_i(full_o), .empty_i(empty_o), .deq_v_i(deq_v_o));

// File: testbench/fifo_tb.sv
/*
 * Testbench for the packet FIFO. Replays the stimulus file twice with a
 * reset in between and compares the outputs every cycle.
 */

`timescale 1ns/1ps

`include "fifo_defs.svh"

module fifo_tb;

  localparam int reset_cycles = 5;

  logic                    clk;
  logic                    reset;
  logic                    enq;
  logic [`FIFO_DATA_W-1:0] enq_data;
  logic                    deq;
  logic                    deq_v;
  logic [`FIFO_DATA_W-1:0] deq_data;
  logic                    parity_err;
  fifo_pkg::count_t        count;
  logic                    full;
  logic                    empty;

  logic                    enq_q [$];
  logic                    deq_q [$];
  logic [`FIFO_DATA_W-1:0] data_q [$];
  logic                    exp_v_q [$];
  logic [`FIFO_DATA_W-1:0] exp_data_q [$];

  int num_lines;
  int model_count;
  int check_count;
  int error_count;

  fifo_1r1w_top UUT
    (.clk_i       (clk)
    ,.reset_i     (reset)
    ,.enq_i       (enq)
    ,.enq_data_i  (enq_data)
    ,.deq_i       (deq)
    ,.deq_v_o     (deq_v)
    ,.deq_data_o  (deq_data)
    ,.parity_err_o(parity_err)
    ,.count_o     (count)
    ,.full_o      (full)
    ,.empty_o     (empty)
    );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic load_stimulus;
    int    fd;
    int    n;
    int    f_enq;
    int    f_deq;
    int    f_data;
    int    f_exp_v;
    int    f_exp_data;
    string line;
    fd = $fopen("testbench/fifo_stimulus.txt", "r");
    if (fd == 0)
    begin
      error_count++;
      $display("cannot open the stimulus file");
      return;
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#")
      begin
        n = $sscanf(line, "%h %h %h %h %h", f_enq, f_deq, f_data, f_exp_v, f_exp_data);
        if (n == 5)
        begin
          enq_q.push_back(f_enq[0]);
          deq_q.push_back(f_deq[0]);
          data_q.push_back(f_data[`FIFO_DATA_W-1:0]);
          exp_v_q.push_back(f_exp_v[0]);
          exp_data_q.push_back(f_exp_data[`FIFO_DATA_W-1:0]);
        end
      end
    end
    $fclose(fd);
    num_lines = enq_q.size();
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    assert (got === exp)
    else
    begin
      error_count++;
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs(input logic exp_v, input logic [`FIFO_DATA_W-1:0] exp_data);
    check_value("deq_v_o", 32'(deq_v), 32'(exp_v));
    if (exp_v)
      check_value("deq_data_o", 32'(deq_data), 32'(exp_data));
    check_value("parity_err_o", 32'(parity_err), 32'd0);
    check_value("count_o", 32'(count), 32'(model_count));
    check_value("full_o", 32'(full), 32'(model_count == `FIFO_DEPTH));
    check_value("empty_o", 32'(empty), 32'(model_count == 0));
  endtask

  // Occupancy follows the strobe rules: drop on full, ignore on empty.
  task automatic update_model(input logic e, input logic d);
    logic enq_acc;
    logic deq_acc;
    enq_acc     = e && (model_count < `FIFO_DEPTH);
    deq_acc     = d && (model_count > 0);
    model_count = model_count + int'(enq_acc) - int'(deq_acc);
  endtask

  task automatic apply_reset;
    @(posedge clk);
    #1;
    reset       = 1'b1;
    enq         = 1'b0;
    deq         = 1'b0;
    enq_data    = '0;
    model_count = 0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic replay_stimulus;
    int                      i;
    logic                    prev_v;
    logic [`FIFO_DATA_W-1:0] prev_data;
    prev_v    = 1'b0;
    prev_data = '0;
    for (i = 0; i < num_lines; i++)
    begin
      @(posedge clk);
      #1;
      enq      = enq_q[i];
      deq      = deq_q[i];
      enq_data = data_q[i];
      // Outputs here still answer the previous line.
      @(negedge clk);
      check_outputs(prev_v, prev_data);
      update_model(enq_q[i], deq_q[i]);
      prev_v    = exp_v_q[i];
      prev_data = exp_data_q[i];
    end
    @(posedge clk);
    #1;
    enq = 1'b0;
    deq = 1'b0;
    @(negedge clk);
    check_outputs(prev_v, prev_data);
  endtask

  initial
  begin : watchdog
    wait (num_lines > 0);
    repeat (2 * (num_lines + 2 + reset_cycles) + 20) @(posedge clk);
    $display("timeout: the run did not finish in the expected number of cycles");
    $display("%0d checks, %0d errors", check_count, error_count);
    $display("*** FAILED ***");
    $finish;
  end

  initial
  begin : main
    reset       = 1'b1;
    enq         = 1'b0;
    deq         = 1'b0;
    enq_data    = '0;
    model_count = 0;
    check_count = 0;
    error_count = 0;
    load_stimulus();
    if (num_lines == 0)
    begin
      error_count++;
      $display("the stimulus file holds no usable lines");
    end
    apply_reset();
    replay_stimulus();
    // Second pass starts from a reset while the FIFO still holds entries.
    apply_reset();
    replay_stimulus();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: testbench/fifo_stimulus.txt
# Columns: enq deq payload exp_v exp_data, in hex, one clock cycle per line.
# The exp columns give deq_v_o and deq_data_o one cycle after the line's strobes.
1 0 a001 0 0000
1 0 a002 0 0000
1 0 a003 0 0000
0 1 0000 1 a001
0 1 0000 1 a002
0 1 0000 1 a003
0 1 0000 0 0000
1 0 b001 0 0000
1 1 b002 1 b001
1 1 b003 1 b002
1 1 b004 1 b003
1 1 b005 1 b004
1 1 b006 1 b005
0 1 0000 1 b006
1 1 c001 0 0000
0 1 0000 1 c001
1 0 d000 0 0000
1 0 d001 0 0000
1 0 d002 0 0000
1 0 d003 0 0000
1 0 d004 0 0000
1 0 d005 0 0000
1 0 d006 0 0000
1 0 d007 0 0000
1 0 d008 0 0000
1 0 d009 0 0000
1 0 d00a 0 0000
1 0 d00b 0 0000
1 0 d00c 0 0000
1 0 d00d 0 0000
1 0 d00e 0 0000
1 0 d00f 0 0000
1 0 e0ee 0 0000
1 1 f0ff 1 d000
1 1 f100 1 d001
0 1 0000 1 d002

// File: fifo_1r1w_top.f
+incdir+include
rtl/fifo_pkg.sv
rtl/mem_1rw_sync.sv
rtl/mem_1r1w_from_1rw.sv
rtl/fifo_ctrl.sv
rtl/fifo_1r1w_top.sv
testbench/fifo_checker.sv
testbench/fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f fifo_1r1w_top.f --top-module fifo_tb -o fifo_sim

./obj_dir/fifo_sim 2>&1 | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log
then
  echo "Simulation passed."
else
  echo "Simulation failed."
  exit 1
fi
